// ==== design/block_tag_table.sv ====
/* Circular table of outstanding block tags. Push stores a tag, pull frees
   the oldest one, seek reports whether any live entry matches. */

`timescale 1ns/1ns

module block_tag_table #(
    parameter int NB_TOKEN = 4,
    parameter int TOKEN_W  = 28
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               srst,
    // Lookup
    input  logic [TOKEN_W-1:0] seek,
    output logic               hit,
    // Fill and drain
    input  logic               push,
    input  logic               pull,
    input  logic [TOKEN_W-1:0] token,
    // Status
    output logic               full,
    output logic               empty
);

    localparam int PTR_W = (NB_TOKEN > 1) ? $clog2(NB_TOKEN) : 1;

    logic [TOKEN_W-1:0]  tags [NB_TOKEN];
    logic [NB_TOKEN-1:0] tag_valid;
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    // Wrap at NB_TOKEN, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(NB_TOKEN - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////
    // Pointers and valid bits
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            tag_valid <= '0;
        end else if (srst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            tag_valid <= '0;
        end else begin
            // Responses come back in order, so the oldest entry goes first
            if (pull) begin
                tag_valid[rd_ptr] <= 1'b0;
                rd_ptr            <= next_ptr(rd_ptr);
            end
            if (push) begin
                tag_valid[wr_ptr] <= 1'b1;
                wr_ptr            <= next_ptr(wr_ptr);
            end
        end
    end

    // Tag storage
    always_ff @(posedge aclk) begin
        if (push) begin
            tags[wr_ptr] <= token;
        end
    end

    //////////////////////////////
    // Lookup and status
    //////////////////////////////

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < NB_TOKEN; i++) begin
            if (tag_valid[i] && (tags[i] == seek)) begin
                hit = 1'b1;
            end
        end
    end

    assign full  = &tag_valid;
    assign empty = ~|tag_valid;

endmodule

// ==== design/mem_completion.sv ====
/* Accepts bus responses. Read data is queued for the core to pop and each
   write acknowledge turns into a one-cycle done pulse. */

`timescale 1ns/1ns

module mem_completion #(
    parameter int RQ_DEPTH = 4
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             srst,
    // Read channel
    input  logic                             rvalid,
    input  logic [mem_order_pkg::DATA_W-1:0] rdata,
    output logic                             rready,
    // Write acknowledge
    input  logic                             bvalid,
    output logic                             bready,
    // Core side
    input  logic                             rd_pop,
    output logic [mem_order_pkg::DATA_W-1:0] rd_data,
    output logic                             rd_data_valid,
    output logic                             wr_done,
    // Completed beats for the tracker
    output logic                             rd_fire,
    output logic                             wr_fire
);

    localparam int PTR_W = (RQ_DEPTH > 1) ? $clog2(RQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(RQ_DEPTH + 1);

    logic [mem_order_pkg::DATA_W-1:0] rq_mem [RQ_DEPTH];
    logic [PTR_W-1:0]                 wr_ptr;
    logic [PTR_W-1:0]                 rd_ptr;
    logic [CNT_W-1:0]                 count;
    logic                             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A full queue back-pressures memory
    assign rready  = (count != CNT_W'(RQ_DEPTH));
    assign bready  = 1'b1;
    assign rd_fire = rvalid & rready;
    assign wr_fire = bvalid & bready;
    assign pop     = rd_pop & rd_data_valid;

    //////////////////////////////
    // Read data queue
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            wr_done <= 1'b0;
        end else if (srst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            wr_done <= 1'b0;
        end else begin
            if (rd_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({rd_fire, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Write done pulse
            wr_done <= wr_fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_fire) begin
            rq_mem[wr_ptr] <= rdata;
        end
    end

    assign rd_data       = rq_mem[rd_ptr];
    assign rd_data_valid = (count != '0);

endmodule

// ==== design/mem_order_pkg.sv ====
/* Shared opcode type and default widths for the load/store ordering unit.
   Modules refer to these by scoped name. */

package mem_order_pkg;

    //////////////////////////////
    // Default widths
    //////////////////////////////

    // Byte address width, the top level may override it per instance
    localparam int ADDR_W = 32;

    // Read data width, fixed for the queue and the memory side
    localparam int DATA_W = 32;

    //////////////////////////////
    // Core opcodes
    //////////////////////////////

    // Memory stage operation offered by the core
    // OP_OTHER completes at once and never reaches the bus
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_OTHER = 2'd2
    } mem_op_t;

endpackage

// ==== design/mem_order_unit.sv ====
/* Top of the load/store ordering unit between the core memory stage and the
   memory bus. Sets the parameters and wires issuer, tracker and completion. */

`timescale 1ns/1ns

module mem_order_unit #(
    parameter int ORDERING = 1,
    parameter int MAX_OR   = 4,
    parameter int ADDR_W   = mem_order_pkg::ADDR_W,
    parameter int BLOCK_W  = 128,
    parameter int RQ_DEPTH = 4
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             srst,
    // Core side
    input  logic                             req_valid,
    input  mem_order_pkg::mem_op_t           req_op,
    input  logic [ADDR_W-1:0]                req_addr,
    output logic                             req_ready,
    output logic [mem_order_pkg::DATA_W-1:0] rd_data,
    output logic                             rd_data_valid,
    input  logic                             rd_pop,
    output logic                             wr_done,
    output logic                             busy,
    // Request channel
    output logic                             bus_valid,
    output logic                             bus_wr,
    output logic [ADDR_W-1:0]                bus_addr,
    input  logic                             bus_ready,
    // Read channel
    input  logic                             rvalid,
    input  logic [mem_order_pkg::DATA_W-1:0] rdata,
    output logic                             rready,
    // Write acknowledge
    input  logic                             bvalid,
    output logic                             bready
);

    logic [ADDR_W-1:0] seek_addr;
    logic [ADDR_W-1:0] issue_addr;
    logic              issue_fire;
    logic              issue_wr;
    logic              rd_fire;
    logic              wr_fire;
    logic              wr_coll;
    logic              rd_coll;
    logic              max_wr_or;
    logic              max_rd_or;
    logic              pending_wr;
    logic              pending_rd;

    mem_req_issuer #(
        .ADDR_W (ADDR_W)
    ) u_issuer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .bus_valid  (bus_valid),
        .bus_wr     (bus_wr),
        .bus_addr   (bus_addr),
        .bus_ready  (bus_ready),
        .seek_addr  (seek_addr),
        .wr_coll    (wr_coll),
        .rd_coll    (rd_coll),
        .max_wr_or  (max_wr_or),
        .max_rd_or  (max_rd_or),
        .issue_fire (issue_fire),
        .issue_wr   (issue_wr),
        .issue_addr (issue_addr)
    );

    mem_ordering #(
        .ORDERING (ORDERING),
        .MAX_OR   (MAX_OR),
        .ADDR_W   (ADDR_W),
        .BLOCK_W  (BLOCK_W)
    ) u_ordering (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .issue_fire (issue_fire),
        .issue_wr   (issue_wr),
        .issue_addr (issue_addr),
        .seek_addr  (seek_addr),
        .rd_fire    (rd_fire),
        .wr_fire    (wr_fire),
        .wr_coll    (wr_coll),
        .rd_coll    (rd_coll),
        .max_wr_or  (max_wr_or),
        .max_rd_or  (max_rd_or),
        .pending_wr (pending_wr),
        .pending_rd (pending_rd)
    );

    mem_completion #(
        .RQ_DEPTH (RQ_DEPTH)
    ) u_completion (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .srst          (srst),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rready        (rready),
        .bvalid        (bvalid),
        .bready        (bready),
        .rd_pop        (rd_pop),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .wr_done       (wr_done),
        .rd_fire       (rd_fire),
        .wr_fire       (wr_fire)
    );

    // Outstanding in either direction
    assign busy = pending_wr | pending_rd;

endmodule

// ==== design/mem_ordering.sv ====
/* Tracks outstanding loads and stores and raises the collision and limit
   flags that gate the issuer. ORDERING picks counters or block tag tables. */

`timescale 1ns/1ns

module mem_ordering #(
    parameter int ORDERING = 1,
    parameter int MAX_OR   = 4,
    parameter int ADDR_W   = 32,
    parameter int BLOCK_W  = 128
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    // Request accepted on the bus
    input  logic              issue_fire,
    input  logic              issue_wr,
    input  logic [ADDR_W-1:0] issue_addr,
    // Address of the request waiting in the issuer
    input  logic [ADDR_W-1:0] seek_addr,
    // Responses accepted by the completion unit
    input  logic              rd_fire,
    input  logic              wr_fire,
    // Status flags
    output logic              wr_coll,
    output logic              rd_coll,
    output logic              max_wr_or,
    output logic              max_rd_or,
    output logic              pending_wr,
    output logic              pending_rd
);

    localparam int OFFSET_W = $clog2(BLOCK_W / 8);
    localparam int TAG_W    = ADDR_W - OFFSET_W;
    localparam int CNT_W    = $clog2(MAX_OR + 1);

    logic             push_wr;
    logic             push_rd;
    logic [CNT_W-1:0] wr_or_cnt;
    logic [CNT_W-1:0] rd_or_cnt;
    logic             wr_cnt_max;
    logic             rd_cnt_max;

    assign push_wr = issue_fire & issue_wr;
    assign push_rd = issue_fire & ~issue_wr;

    //////////////////////////////
    // Outstanding counters
    //////////////////////////////

    // Push and pull in the same cycle cancel out
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_or_cnt <= '0;
            rd_or_cnt <= '0;
        end else if (srst) begin
            wr_or_cnt <= '0;
            rd_or_cnt <= '0;
        end else begin
            case ({push_wr, wr_fire})
                2'b10:   wr_or_cnt <= wr_or_cnt + 1'b1;
                2'b01:   wr_or_cnt <= wr_or_cnt - 1'b1;
                default: wr_or_cnt <= wr_or_cnt;
            endcase
            case ({push_rd, rd_fire})
                2'b10:   rd_or_cnt <= rd_or_cnt + 1'b1;
                2'b01:   rd_or_cnt <= rd_or_cnt - 1'b1;
                default: rd_or_cnt <= rd_or_cnt;
            endcase
        end
    end

    assign wr_cnt_max = (wr_or_cnt == CNT_W'(MAX_OR));
    assign rd_cnt_max = (rd_or_cnt == CNT_W'(MAX_OR));

    generate
        if (ORDERING == 0) begin : g_strict
            // Any outstanding request of one kind blocks the other kind
            assign pending_wr = (wr_or_cnt != '0);
            assign pending_rd = (rd_or_cnt != '0);
            assign wr_coll    = pending_wr;
            assign rd_coll    = pending_rd;
            assign max_wr_or  = wr_cnt_max;
            assign max_rd_or  = rd_cnt_max;
        end else begin : g_block
            logic wr_full;
            logic wr_empty;
            logic rd_full;
            logic rd_empty;

            // Only a match on the same cache block collides
            block_tag_table #(
                .NB_TOKEN (MAX_OR),
                .TOKEN_W  (TAG_W)
            ) wr_tags (
                .aclk    (aclk),
                .aresetn (aresetn),
                .srst    (srst),
                .seek    (seek_addr[ADDR_W-1:OFFSET_W]),
                .hit     (wr_coll),
                .push    (push_wr),
                .pull    (wr_fire),
                .token   (issue_addr[ADDR_W-1:OFFSET_W]),
                .full    (wr_full),
                .empty   (wr_empty)
            );

            block_tag_table #(
                .NB_TOKEN (MAX_OR),
                .TOKEN_W  (TAG_W)
            ) rd_tags (
                .aclk    (aclk),
                .aresetn (aresetn),
                .srst    (srst),
                .seek    (seek_addr[ADDR_W-1:OFFSET_W]),
                .hit     (rd_coll),
                .push    (push_rd),
                .pull    (rd_fire),
                .token   (issue_addr[ADDR_W-1:OFFSET_W]),
                .full    (rd_full),
                .empty   (rd_empty)
            );

            assign pending_wr = ~wr_empty;
            assign pending_rd = ~rd_empty;
            assign max_wr_or  = wr_cnt_max | wr_full;
            assign max_rd_or  = rd_cnt_max | rd_full;
        end
    endgenerate

endmodule

// ==== design/mem_req_issuer.sv ====
/* Takes one request from the core, holds it while ordering forbids it and
   then drives it on the bus until memory accepts it. */

`timescale 1ns/1ns

module mem_req_issuer #(
    parameter int ADDR_W = 32
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   srst,
    // Core side
    input  logic                   req_valid,
    input  mem_order_pkg::mem_op_t req_op,
    input  logic [ADDR_W-1:0]      req_addr,
    output logic                   req_ready,
    // Bus side
    output logic                   bus_valid,
    output logic                   bus_wr,
    output logic [ADDR_W-1:0]      bus_addr,
    input  logic                   bus_ready,
    // Ordering tracker
    output logic [ADDR_W-1:0]      seek_addr,
    input  logic                   wr_coll,
    input  logic                   rd_coll,
    input  logic                   max_wr_or,
    input  logic                   max_rd_or,
    output logic                   issue_fire,
    output logic                   issue_wr,
    output logic [ADDR_W-1:0]      issue_addr
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        HOLD  = 2'd1,
        ISSUE = 2'd2
    } issuer_state_t;

    issuer_state_t     state;
    logic              wr_q;
    logic [ADDR_W-1:0] addr_q;
    logic              blocked;

    // Loads wait on stores and stores wait on loads
    assign blocked = wr_q ? (rd_coll | max_wr_or) : (wr_coll | max_rd_or);

    //////////////////////////////
    // Request FSM
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
            wr_q  <= 1'b0;
        end else if (srst) begin
            state <= IDLE;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        case (req_op)
                            mem_order_pkg::OP_LOAD: begin
                                wr_q  <= 1'b0;
                                state <= HOLD;
                            end
                            mem_order_pkg::OP_STORE: begin
                                wr_q  <= 1'b1;
                                state <= HOLD;
                            end
                            // Nothing to send, done in this cycle
                            default: state <= IDLE;
                        endcase
                    end
                end
                HOLD: begin
                    if (!blocked) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (bus_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Held address
    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            addr_q <= req_addr;
        end
    end

    assign req_ready  = (state == IDLE);
    assign bus_valid  = (state == ISSUE);
    assign bus_wr     = wr_q;
    assign bus_addr   = addr_q;
    assign seek_addr  = addr_q;
    assign issue_fire = bus_valid & bus_ready;
    assign issue_wr   = wr_q;
    assign issue_addr = addr_q;

endmodule

// ==== sim.f ====
design/mem_order_pkg.sv
design/block_tag_table.sv
design/mem_ordering.sv
design/mem_req_issuer.sv
design/mem_completion.sv
design/mem_order_unit.sv
test/mem_resp_model.sv
test/tb_mem_order_unit.sv

// ==== test/mem_resp_model.sv ====
/* Behavioral memory for the testbench. Accepts bus requests and answers
   reads and writes in order, each after a random latency of 1 to 8 cycles. */

`timescale 1ns/1ns

module mem_resp_model #(
    parameter int          ADDR_W = 32,
    parameter logic [31:0] RD_KEY = 32'h0,
    parameter int          SEED   = 72
) (
    input  logic                             aclk,
    input  logic                             bus_valid,
    input  logic                             bus_wr,
    input  logic [ADDR_W-1:0]                bus_addr,
    output logic                             bus_ready,
    output logic                             rvalid,
    output logic [mem_order_pkg::DATA_W-1:0] rdata,
    input  logic                             rready,
    output logic                             bvalid,
    input  logic                             bready
);

    int                seed;
    int                cycle;
    logic              req_acc;
    logic              req_wr;
    logic [ADDR_W-1:0] req_addr;
    logic              r_acc;
    logic              b_acc;
    int                rd_due_q[$];
    logic [ADDR_W-1:0] rd_addr_q[$];
    int                wr_due_q[$];

    // Sample at the falling edge, update just after the rising edge
    initial begin
        seed      = SEED;
        cycle     = 0;
        bus_ready = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        bvalid    = 1'b0;
        forever begin
            @(negedge aclk);
            req_acc  = bus_valid && bus_ready;
            req_wr   = bus_wr;
            req_addr = bus_addr;
            r_acc    = rvalid && rready;
            b_acc    = bvalid && bready;
            @(posedge aclk);
            #5;
            cycle++;
            if (req_acc && req_wr) begin
                wr_due_q.push_back(cycle + 1 + ({$random(seed)} % 8));
            end else if (req_acc) begin
                rd_due_q.push_back(cycle + 1 + ({$random(seed)} % 8));
                rd_addr_q.push_back(req_addr);
            end
            // Valid and payload stay put until accepted
            if (r_acc) begin
                rvalid = 1'b0;
            end
            if (!rvalid && rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                void'(rd_due_q.pop_front());
                rdata  = rd_addr_q.pop_front() ^ RD_KEY;
                rvalid = 1'b1;
            end
            if (b_acc) begin
                bvalid = 1'b0;
            end
            if (!bvalid && wr_due_q.size() > 0 && wr_due_q[0] <= cycle) begin
                void'(wr_due_q.pop_front());
                bvalid = 1'b1;
            end
            bus_ready = ({$random(seed)} % 4) != 0;
        end
    end

endmodule

// ==== test/tb_mem_order_unit.sv ====
/* Testbench for the load/store ordering unit. Runs loads and stores against
   a behavioral memory and checks ordering, limits, read data and done pulses. */

`timescale 1ns/1ns

module tb_mem_order_unit #(
    parameter int ORDERING_TB = 1
);

    localparam int          MAX_OR   = 4;
    localparam int          RQ_DEPTH = 4;
    localparam int          OFF_W    = 4;
    localparam int          N_FILL   = RQ_DEPTH + 2;
    localparam int          N_REQ    = 300;
    localparam logic [31:0] RD_KEY   = 32'hA5C3_0F96;

    logic                   aclk;
    logic                   aresetn;
    logic                   srst;
    logic                   req_valid;
    mem_order_pkg::mem_op_t req_op;
    logic [31:0]            req_addr;
    logic                   req_ready;
    logic [31:0]            rd_data;
    logic                   rd_data_valid;
    logic                   rd_pop;
    logic                   wr_done;
    logic                   busy;
    logic                   bus_valid;
    logic                   bus_wr;
    logic [31:0]            bus_addr;
    logic                   bus_ready;
    logic                   rvalid;
    logic [31:0]            rdata;
    logic                   rready;
    logic                   bvalid;
    logic                   bready;

    int                     seed;
    logic                   pop_en;
    int                     n_loads;
    int                     n_stores;
    int                     n_pops;
    int                     n_rd_resp;
    int                     n_wr_done;
    int                     n_rd_issue;
    int                     n_wr_issue;
    int                     q_count;
    logic                   prev_bfire;
    logic [31:0]            taken_addr;
    logic                   taken_wr;
    logic [31:0]            rd_out_q[$];
    logic [31:0]            wr_out_q[$];
    logic [31:0]            exp_data_q[$];

    mem_order_unit #(
        .ORDERING (ORDERING_TB),
        .MAX_OR   (MAX_OR),
        .RQ_DEPTH (RQ_DEPTH)
    ) uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .srst          (srst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_ready     (req_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_pop        (rd_pop),
        .wr_done       (wr_done),
        .busy          (busy),
        .bus_valid     (bus_valid),
        .bus_wr        (bus_wr),
        .bus_addr      (bus_addr),
        .bus_ready     (bus_ready),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rready        (rready),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    mem_resp_model #(
        .ADDR_W (32),
        .RD_KEY (RD_KEY),
        .SEED   (72)
    ) mem (
        .aclk      (aclk),
        .bus_valid (bus_valid),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_ready (bus_ready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rready    (rready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Word that a load of addr returns
    function automatic logic [31:0] exp_rdata(input logic [31:0] addr);
        return addr ^ RD_KEY;
    endfunction

    // Outstanding request of the other kind that must block this one
    function automatic bit order_violated(input logic wr, input logic [31:0] addr);
        bit hit;
        hit = 1'b0;
        if (wr) begin
            for (int i = 0; i < rd_out_q.size(); i++) begin
                if (ORDERING_TB == 0 || rd_out_q[i][31:OFF_W] == addr[31:OFF_W]) begin
                    hit = 1'b1;
                end
            end
        end else begin
            for (int i = 0; i < wr_out_q.size(); i++) begin
                if (ORDERING_TB == 0 || wr_out_q[i][31:OFF_W] == addr[31:OFF_W]) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Called just after a rising edge, returns just after the edge of the take
    task automatic send_req(input mem_order_pkg::mem_op_t op, input logic [31:0] addr);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        do begin
            @(negedge aclk);
        end while (!req_ready);
        @(posedge aclk);
        #5;
        req_valid = 1'b0;
        if (op == mem_order_pkg::OP_LOAD) begin
            n_loads++;
            exp_data_q.push_back(exp_rdata(addr));
            taken_addr = addr;
            taken_wr   = 1'b0;
        end else if (op == mem_order_pkg::OP_STORE) begin
            n_stores++;
            taken_addr = addr;
            taken_wr   = 1'b1;
        end
    endtask

    //////////////////////////////
    // Clock, pops and watchdog
    //////////////////////////////

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    initial begin
        rd_pop = 1'b0;
        forever begin
            @(posedge aclk);
            #5;
            rd_pop = pop_en && (({$random(seed)} % 3) != 0);
        end
    end

    initial begin
        repeat ((N_REQ + N_FILL) * 40 + 20) @(posedge aclk);
        $display("timeout: requests did not complete");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    //////////////////////////////
    // Compare process
    //////////////////////////////

    initial begin
        n_pops     = 0;
        n_rd_resp  = 0;
        n_wr_done  = 0;
        n_rd_issue = 0;
        n_wr_issue = 0;
        q_count    = 0;
        prev_bfire = 1'b0;
        wait (aresetn === 1'b1);
        forever begin
            @(negedge aclk);
            // State after the last rising edge
            check_val("rready", rready, q_count != RQ_DEPTH);
            check_val("bready", bready, 1);
            check_val("rd_data_valid", rd_data_valid, q_count != 0);
            check_val("wr_done", wr_done, prev_bfire);
            check_val("busy", busy, (rd_out_q.size() + wr_out_q.size()) != 0);
            if (wr_done) begin
                n_wr_done++;
            end
            if (bus_valid && bus_ready) begin
                check_val("bus issue ordering", order_violated(bus_wr, bus_addr), 0);
                check_val("bus_addr", bus_addr, taken_addr);
                check_val("bus_wr", bus_wr, taken_wr);
            end
            // Transfers taken at the coming rising edge
            if (rvalid && rready) begin
                void'(rd_out_q.pop_front());
                q_count++;
                n_rd_resp++;
            end
            if (bvalid && bready) begin
                void'(wr_out_q.pop_front());
            end
            prev_bfire = bvalid && bready;
            if (bus_valid && bus_ready && bus_wr) begin
                wr_out_q.push_back(bus_addr);
                n_wr_issue++;
            end else if (bus_valid && bus_ready) begin
                rd_out_q.push_back(bus_addr);
                n_rd_issue++;
            end
            check_val("outstanding stores", wr_out_q.size() > MAX_OR, 0);
            check_val("outstanding loads", rd_out_q.size() > MAX_OR, 0);
            if (rd_pop && rd_data_valid) begin
                check_val("rd_data", rd_data, exp_data_q.pop_front());
                q_count--;
                n_pops++;
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int          pick;
        logic [31:0] addr;
        seed       = 72;
        aresetn    = 1'b0;
        srst       = 1'b0;
        req_valid  = 1'b0;
        req_op     = mem_order_pkg::OP_OTHER;
        req_addr   = '0;
        pop_en     = 1'b0;
        n_loads    = 0;
        n_stores   = 0;
        taken_addr = '0;
        taken_wr   = 1'b0;
        repeat (10) @(posedge aclk);
        #5;
        aresetn = 1'b1;
        @(negedge aclk);
        check_val("bus_valid", bus_valid, 0);
        check_val("rd_data_valid", rd_data_valid, 0);
        check_val("wr_done", wr_done, 0);
        check_val("busy", busy, 0);
        check_val("req_ready", req_ready, 1);
        @(posedge aclk);
        #5;
        // Fill the read queue with pops held off
        for (int i = 0; i < N_FILL; i++) begin
            send_req(mem_order_pkg::OP_LOAD, 32'h0000_2000 + 32'(i * 4));
        end
        wait (q_count == RQ_DEPTH);
        repeat (8) @(negedge aclk);
        check_val("rready with full queue", rready, 0);
        @(posedge aclk);
        #5;
        pop_en = 1'b1;
        // Four blocks only, so collisions are frequent
        for (int i = 0; i < N_REQ; i++) begin
            pick = {$random(seed)} % 8;
            addr = 32'h0000_1000 + (({$random(seed)} % 4) << OFF_W)
                 + (({$random(seed)} % 4) << 2);
            if (pick < 4) begin
                send_req(mem_order_pkg::OP_LOAD, addr);
            end else if (pick < 7) begin
                send_req(mem_order_pkg::OP_STORE, addr);
            end else begin
                send_req(mem_order_pkg::OP_OTHER, addr);
            end
        end
        wait (n_pops == n_loads && n_wr_done == n_stores);
        repeat (4) @(negedge aclk);
        check_val("busy at end", busy, 0);
        check_val("loads issued", n_rd_issue, n_loads);
        check_val("stores issued", n_wr_issue, n_stores);
        check_val("read responses", n_rd_resp, n_loads);
        check_val("write done pulses", n_wr_done, n_stores);
        $display("NO ERRORS");
        $finish;
    end

endmodule
